// ==== hw/network_config_pkg.sv ====
package network_config_pkg;

    // network dimensions
    localparam int NET_NUM_INP = 4;
    localparam int NET_NUM_NEUR = 4;

    // numeric widths
    localparam int NET_CHARGE_WIDTH = 8;
    localparam int NET_POT_WIDTH = 16;
    localparam int NET_WEIGHT_WIDTH = 4;
    localparam int NET_TICK_WIDTH = 16;

    typedef logic signed [NET_CHARGE_WIDTH-1:0] charge_t;
    typedef logic signed [NET_WEIGHT_WIDTH-1:0] weight_t;
    // membrane potential, also the weighted sum into a neuron
    typedef logic signed [NET_POT_WIDTH-1:0] potential_t;
    typedef logic [NET_NUM_NEUR-1:0] spike_vec_t;
    typedef logic [NET_TICK_WIDTH-1:0] tick_t;

    // fixed synapse weights, one row per neuron and one column per input
    localparam weight_t NET_WEIGHTS [NET_NUM_NEUR][NET_NUM_INP] = '{
        '{weight_t'(7), weight_t'(2), weight_t'(0), weight_t'(-3)},
        '{weight_t'(-2), weight_t'(6), weight_t'(3), weight_t'(0)},
        '{weight_t'(0), weight_t'(-4), weight_t'(5), weight_t'(4)},
        '{weight_t'(3), weight_t'(0), weight_t'(-8), weight_t'(7)}
    };

endpackage

// ==== hw/io_config_pkg.sv ====
package io_config_pkg;
    import network_config_pkg::*;

    // packet opcode in the top bit of the input packet
    typedef enum logic [0:0] {
        NOM = 1'b0,
        CLR = 1'b1
    } src_opcode_t;

    localparam int SRC_OPC_WIDTH = 1;
    localparam int SRC_WIDTH = SRC_OPC_WIDTH + NET_NUM_INP * NET_CHARGE_WIDTH;

    // opcode on top, input 0 charge right below it
    typedef struct packed {
        src_opcode_t opcode;
        charge_t [0:NET_NUM_INP-1] charge;
    } src_packet_t;

    // decoded packet between source and synapse stage
    typedef struct packed {
        logic clr;
        charge_t [NET_NUM_INP-1:0] charge;
    } charge_beat_t;

    // weighted sums between synapse and neuron stage
    typedef struct packed {
        logic clr;
        potential_t [NET_NUM_NEUR-1:0] sum;
    } sum_beat_t;

    // spike vector between neuron stage and sink
    typedef struct packed {
        logic clr;
        spike_vec_t spikes;
    } spike_beat_t;

    // output packet, spikes above the tick index
    typedef struct packed {
        spike_vec_t spikes;
        tick_t tick;
    } out_packet_t;

endpackage

// ==== hw/network_source.sv ====
`timescale 1ns/1ns

module network_source (
    input  logic                        clk,
    input  logic                        arstn,
    // input packet handshake
    input  logic                        src_valid,
    output logic                        src_ready,
    input  io_config_pkg::src_packet_t  src,
    // charge beat handshake toward the synapse stage
    output logic                        chg_valid,
    input  logic                        chg_ready,
    output io_config_pkg::charge_beat_t chg
);
    import network_config_pkg::*;
    import io_config_pkg::*;

    charge_beat_t beat_d;
    charge_beat_t beat_q;
    logic valid_q;
    logic accept;

    // room for a new packet when empty or when the held beat leaves now
    assign src_ready = !valid_q || chg_ready;
    assign accept = src_valid && src_ready;

    // decode the opcode into the clear flag
    always_comb begin
        beat_d.clr = (src.opcode == CLR);
        for (int i = 0; i < NET_NUM_INP; i++) begin
            // charges still pass on a clear beat and later stages ignore them
            beat_d.charge[i] = src.charge[i];
        end
    end

    // occupancy of the pipeline register
    always_ff @(posedge clk) begin
        if (!arstn) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (chg_ready) begin
            valid_q <= 1'b0;
        end
    end

    // payload only changes on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= beat_d;
        end
    end

    assign chg_valid = valid_q;
    assign chg = beat_q;

endmodule

// ==== hw/synapse_stage.sv ====
`timescale 1ns/1ns

module synapse_stage (
    input  logic                        clk,
    input  logic                        arstn,
    // charge beat from the source
    input  logic                        chg_valid,
    output logic                        chg_ready,
    input  io_config_pkg::charge_beat_t chg,
    // weighted sums toward the neuron stage
    output logic                        sum_valid,
    input  logic                        sum_ready,
    output io_config_pkg::sum_beat_t    sum
);
    import network_config_pkg::*;
    import io_config_pkg::*;

    // one product per synapse
    potential_t prod [NET_NUM_NEUR][NET_NUM_INP];
    sum_beat_t beat_d;
    sum_beat_t beat_q;
    logic valid_q;
    logic accept;

    // same handshake as every stage
    assign chg_ready = !valid_q || sum_ready;
    assign accept = chg_valid && chg_ready;

    // charge times weight, both sign extended first
    always_comb begin
        for (int n = 0; n < NET_NUM_NEUR; n++) begin
            for (int i = 0; i < NET_NUM_INP; i++) begin
                prod[n][i] = potential_t'(chg.charge[i]) * potential_t'(NET_WEIGHTS[n][i]);
            end
        end
    end

    // sum over inputs per neuron
    // worst case magnitude is 4 * 128 * 8, well inside the potential range
    always_comb begin
        beat_d.clr = chg.clr;
        for (int n = 0; n < NET_NUM_NEUR; n++) begin
            beat_d.sum[n] = '0;
            for (int i = 0; i < NET_NUM_INP; i++) begin
                beat_d.sum[n] = beat_d.sum[n] + prod[n][i];
            end
        end
    end

    // register occupancy
    always_ff @(posedge clk) begin
        if (!arstn) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (sum_ready) begin
            valid_q <= 1'b0;
        end
    end

    // sums and clear flag travel together
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= beat_d;
        end
    end

    assign sum_valid = valid_q;
    assign sum = beat_q;

endmodule

// ==== hw/neuron_stage.sv ====
`timescale 1ns/1ns

module neuron_stage #(
    parameter network_config_pkg::potential_t THRESHOLD = 64,
    parameter int LEAK_SHIFT = 3
) (
    input  logic                        clk,
    input  logic                        arstn,
    // weighted sums from the synapse stage
    input  logic                        sum_valid,
    output logic                        sum_ready,
    input  io_config_pkg::sum_beat_t    sum,
    // spikes toward the sink
    output logic                        spk_valid,
    input  logic                        spk_ready,
    output io_config_pkg::spike_beat_t  spk
);
    import network_config_pkg::*;
    import io_config_pkg::*;

    // two spare bits hold decay plus sum before saturation
    typedef logic signed [NET_POT_WIDTH+1:0] pot_wide_t;

    // potential limits at the wide width
    localparam pot_wide_t POT_MAX = {3'b000, {(NET_POT_WIDTH - 1){1'b1}}};
    localparam pot_wide_t POT_MIN = {3'b111, {(NET_POT_WIDTH - 1){1'b0}}};

    potential_t pot_q [NET_NUM_NEUR];
    potential_t pot_d [NET_NUM_NEUR];
    pot_wide_t raw [NET_NUM_NEUR];
    potential_t sat [NET_NUM_NEUR];
    spike_vec_t fire;
    spike_beat_t beat_q;
    logic valid_q;
    logic accept;

    assign sum_ready = !valid_q || spk_ready;
    assign accept = sum_valid && sum_ready;

    // leaky integrate and fire, one neuron per iteration
    always_comb begin
        for (int n = 0; n < NET_NUM_NEUR; n++) begin
            // leak takes away the potential shifted right by LEAK_SHIFT
            raw[n] = pot_wide_t'(pot_q[n]) - pot_wide_t'(pot_q[n] >>> LEAK_SHIFT)
                     + pot_wide_t'(sum.sum[n]);
            // clamp to the potential range
            if (raw[n] > POT_MAX) begin
                sat[n] = potential_t'(POT_MAX);
            end else if (raw[n] < POT_MIN) begin
                sat[n] = potential_t'(POT_MIN);
            end else begin
                sat[n] = potential_t'(raw[n]);
            end
            fire[n] = (sat[n] >= THRESHOLD);
            // a neuron that fires starts again from zero
            pot_d[n] = fire[n] ? '0 : sat[n];
        end
    end

    // potentials move on accept, not when the spike beat leaves
    always_ff @(posedge clk) begin
        if (!arstn) begin
            valid_q <= 1'b0;
            for (int n = 0; n < NET_NUM_NEUR; n++) begin
                pot_q[n] <= '0;
            end
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
            end else if (spk_ready) begin
                valid_q <= 1'b0;
            end
            if (accept) begin
                for (int n = 0; n < NET_NUM_NEUR; n++) begin
                    pot_q[n] <= sum.clr ? '0 : pot_d[n];
                end
            end
        end
    end

    // clear beat carries no spikes
    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q.clr <= sum.clr;
            beat_q.spikes <= sum.clr ? '0 : fire;
        end
    end

    assign spk_valid = valid_q;
    assign spk = beat_q;

endmodule

// ==== hw/network_sink.sv ====
`timescale 1ns/1ns

module network_sink (
    input  logic                        clk,
    input  logic                        arstn,
    // spike beat from the neuron stage
    input  logic                        spk_valid,
    output logic                        spk_ready,
    input  io_config_pkg::spike_beat_t  spk,
    // output packet
    output logic                        out_valid,
    input  logic                        out_ready,
    output io_config_pkg::out_packet_t  out
);
    import network_config_pkg::*;
    import io_config_pkg::*;

    // counts NOM beats since reset or the last clear
    tick_t tick_q;
    out_packet_t pkt_q;
    logic valid_q;
    logic accept;

    assign spk_ready = !valid_q || out_ready;
    assign accept = spk_valid && spk_ready;

    // occupancy and tick counter
    always_ff @(posedge clk) begin
        if (!arstn) begin
            valid_q <= 1'b0;
            tick_q <= '0;
        end else begin
            if (accept) begin
                valid_q <= 1'b1;
            end else if (out_ready) begin
                valid_q <= 1'b0;
            end
            // clear restarts the count so the next NOM beat is tick zero
            if (accept) begin
                tick_q <= spk.clr ? '0 : tick_q + 1'b1;
            end
        end
    end

    // NOM packet takes the tick before the increment
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt_q.spikes <= spk.clr ? '0 : spk.spikes;
            pkt_q.tick <= spk.clr ? '0 : tick_q;
        end
    end

    assign out_valid = valid_q;
    assign out = pkt_q;

endmodule

// ==== hw/network_top.sv ====
`timescale 1ns/1ns

module network_top #(
    parameter network_config_pkg::potential_t THRESHOLD = 64,
    parameter int LEAK_SHIFT = 3
) (
    input  logic                        clk,
    input  logic                        arstn,
    // input packets
    input  logic                        src_valid,
    output logic                        src_ready,
    input  io_config_pkg::src_packet_t  src,
    // output packets
    output logic                        out_valid,
    input  logic                        out_ready,
    output io_config_pkg::out_packet_t  out
);
    import io_config_pkg::*;

    // links between the four stages
    logic         chg_valid;
    logic         chg_ready;
    charge_beat_t chg;
    logic         sum_valid;
    logic         sum_ready;
    sum_beat_t    sum;
    logic         spk_valid;
    logic         spk_ready;
    spike_beat_t  spk;

    network_source u_source (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src       (src),
        .chg_valid (chg_valid),
        .chg_ready (chg_ready),
        .chg       (chg)
    );

    synapse_stage u_synapse (
        .clk       (clk),
        .arstn     (arstn),
        .chg_valid (chg_valid),
        .chg_ready (chg_ready),
        .chg       (chg),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum       (sum)
    );

    // firing level and leak come from the top
    neuron_stage #(
        .THRESHOLD  (THRESHOLD),
        .LEAK_SHIFT (LEAK_SHIFT)
    ) u_neuron (
        .clk       (clk),
        .arstn     (arstn),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .sum       (sum),
        .spk_valid (spk_valid),
        .spk_ready (spk_ready),
        .spk       (spk)
    );

    network_sink u_sink (
        .clk       (clk),
        .arstn     (arstn),
        .spk_valid (spk_valid),
        .spk_ready (spk_ready),
        .spk       (spk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

endmodule

// ==== dv/network_model.svh ====
`ifndef NETWORK_MODEL_SVH
`define NETWORK_MODEL_SVH

// model state, advanced once per input packet in input order
int mdl_pot [NET_NUM_NEUR];
int mdl_tick;
// expected output packets and the test name of each
out_packet_t exp_q [$];
string exp_name_q [$];

task automatic reset_model();
    for (int n = 0; n < NET_NUM_NEUR; n++) begin
        mdl_pot[n] = 0;
    end
    mdl_tick = 0;
endtask

// charge times weight summed over all inputs of one neuron
function automatic int weighted_sum(input src_packet_t pkt, input int n);
    int acc;
    acc = 0;
    for (int i = 0; i < NET_NUM_INP; i++) begin
        acc += int'(pkt.charge[i]) * int'(NET_WEIGHTS[n][i]);
    end
    return acc;
endfunction

// limit to the signed potential range
function automatic int clamp_potential(input int v);
    int hi;
    int lo;
    hi = (1 << (NET_POT_WIDTH - 1)) - 1;
    lo = -(1 << (NET_POT_WIDTH - 1));
    if (v > hi) begin
        return hi;
    end
    if (v < lo) begin
        return lo;
    end
    return v;
endfunction

// predicts the output packet for one input packet
task automatic predict_packet(input src_packet_t pkt, input string name);
    out_packet_t exp_pkt;
    int v;
    exp_pkt = '0;
    if (pkt.opcode == CLR) begin
        // clear gives zero spikes, tick zero, and a fresh count
        reset_model();
    end else begin
        for (int n = 0; n < NET_NUM_NEUR; n++) begin
            // leak by arithmetic shift, then integrate the weighted sum
            v = mdl_pot[n] - (mdl_pot[n] >>> LEAK_SHIFT) + weighted_sum(pkt, n);
            v = clamp_potential(v);
            if (v >= THRESHOLD) begin
                exp_pkt.spikes[n] = 1'b1;
                mdl_pot[n] = 0;
            end else begin
                mdl_pot[n] = v;
            end
        end
        exp_pkt.tick = tick_t'(mdl_tick);
        mdl_tick++;
    end
    exp_q.push_back(exp_pkt);
    exp_name_q.push_back(name);
endtask

`endif

// ==== dv/network_tb.sv ====
`timescale 1ns/1ns

module network_tb;
    import network_config_pkg::*;
    import io_config_pkg::*;

    localparam int THRESHOLD = 64;
    localparam int LEAK_SHIFT = 5;
    localparam logic [31:0] SEED = 32'hbc697210;

    // one stimulus row, stall is the out_ready pattern by cycle
    typedef struct {
        string name;
        src_opcode_t opc;
        charge_t chg [NET_NUM_INP];
        bit rnd;
        logic [7:0] stall;
    } row_t;

    logic clk;
    logic arstn;
    logic src_valid;
    logic src_ready;
    src_packet_t src;
    logic out_valid;
    logic out_ready;
    out_packet_t out;

    row_t rows [$];
    int acc_q [$];
    int cycle;
    int timeout_limit;
    int rcv_cnt;
    int inflight;
    int prev_out;
    bit stall_seen;
    bit full_seen;
    bit cur_rnd;
    logic [7:0] cur_stall;
    int err_spikes;
    int err_tick;
    int err_proto;

    `include "network_model.svh"

    network_top #(
        .THRESHOLD  (potential_t'(THRESHOLD)),
        .LEAK_SHIFT (LEAK_SHIFT)
    ) network_top_inst (
        .clk       (clk),
        .arstn     (arstn),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .src       (src),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out)
    );

    always #20 clk = ~clk;

    task automatic check_spikes(input string name, input spike_vec_t exp_v,
                                input spike_vec_t act_v);
        if (act_v !== exp_v) begin
            err_spikes++;
            $display("ERROR %s spikes expected %b actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic check_tick(input string name, input tick_t exp_v, input tick_t act_v);
        if (act_v !== exp_v) begin
            err_tick++;
            $display("ERROR %s tick expected %0d actual %0d", name, exp_v, act_v);
        end
    endtask

    // random rows draw their charges here, before the clock runs
    task automatic add_row(input string name, input src_opcode_t opc, input int c0,
                           input int c1, input int c2, input int c3, input bit rnd,
                           input logic [7:0] stall);
        row_t row;
        row.name = name;
        row.opc = opc;
        row.chg[0] = charge_t'(c0);
        row.chg[1] = charge_t'(c1);
        row.chg[2] = charge_t'(c2);
        row.chg[3] = charge_t'(c3);
        row.rnd = rnd;
        row.stall = stall;
        if (rnd) begin
            for (int i = 0; i < NET_NUM_INP; i++) begin
                row.chg[i] = charge_t'($urandom());
            end
        end
        rows.push_back(row);
    endtask

    task automatic build_table();
        // neuron 0 reaches threshold on the fourth step
        for (int k = 0; k < 5; k++) begin
            add_row("integrate", NOM, 3, 0, 0, 0, 1'b0, 8'hff);
        end
        add_row("weight_in1", NOM, 0, 20, 0, 0, 1'b0, 8'hff);
        add_row("weight_in2_neg", NOM, 0, 0, -100, 0, 1'b0, 8'hff);
        add_row("weight_in3", NOM, 0, 0, 0, 15, 1'b0, 8'hff);
        add_row("weight_in0_neg", NOM, -40, 0, 0, 0, 1'b0, 8'hff);
        // full scale charges push potentials toward the limits
        for (int k = 0; k < 2; k++) begin
            add_row("drive_high", NOM, 127, -128, -128, 127, 1'b0, 8'hff);
        end
        // long negative run, neuron 3 hits the lower limit near the end
        for (int k = 0; k < 20; k++) begin
            add_row("drive_low", NOM, -128, 127, 127, -128, 1'b0, 8'hff);
        end
        add_row("clear", CLR, 0, 0, 0, 0, 1'b0, 8'hff);
        for (int k = 0; k < 5; k++) begin
            add_row("after_clear", NOM, 3, 0, 0, 0, 1'b0, 8'hff);
        end
        // charges on a clear packet must have no effect
        add_row("clear_charged", CLR, 50, 50, 50, 50, 1'b0, 8'hff);
        for (int k = 0; k < 3; k++) begin
            add_row("tick_run", NOM, 1, 1, 1, 1, 1'b0, 8'hff);
        end
        // output mostly stalled, pipeline fills up
        for (int k = 0; k < 6; k++) begin
            add_row("stall_burst", NOM, 10, -5, 8, 2, 1'b0, 8'h01);
        end
        for (int k = 0; k < 16; k++) begin
            add_row("random", NOM, 0, 0, 0, 0, 1'b1, 8'h00);
        end
        add_row("clear_end", CLR, 0, 0, 0, 0, 1'b0, 8'hff);
        add_row("final", NOM, 3, 0, 0, 0, 1'b0, 8'hff);
    endtask

    // one row per transfer, valid held until src_ready
    task automatic drive_rows();
        src_packet_t pkt;
        for (int r = 0; r < rows.size(); r++) begin
            pkt.opcode = rows[r].opc;
            for (int i = 0; i < NET_NUM_INP; i++) begin
                pkt.charge[i] = rows[r].chg[i];
            end
            predict_packet(pkt, rows[r].name);
            src <= pkt;
            src_valid <= 1'b1;
            cur_rnd <= rows[r].rnd;
            cur_stall <= rows[r].stall;
            @(posedge clk);
            while (!src_ready) begin
                @(posedge clk);
            end
        end
        src_valid <= 1'b0;
        cur_rnd <= 1'b0;
        cur_stall <= 8'hff;
    endtask

    // out_ready follows the current row, random rows toss a coin
    always @(posedge clk) begin
        if (cur_rnd) begin
            out_ready <= 1'($urandom() & 1);
        end else begin
            out_ready <= cur_stall[cycle % 8];
        end
    end

    // monitor samples handshakes at the edge
    always @(posedge clk) begin : monitor
        out_packet_t exp_pkt;
        string exp_name;
        int acc;
        bit exp_rdy;
        cycle <= cycle + 1;
        if (arstn) begin
            // src_ready drops only with all four registers full and the output stalled
            exp_rdy = !(inflight == 4 && !out_ready);
            if (src_ready !== exp_rdy) begin
                err_proto++;
                $display("src_ready is %b with %0d beats in flight and out_ready %b",
                         src_ready, inflight, out_ready);
            end
            if (src_ready === 1'b0) begin
                full_seen = 1'b1;
            end
            if (src_valid && src_ready) begin
                acc_q.push_back(cycle);
                inflight++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    err_proto++;
                    $display("an output packet arrived with no input left to match it");
                end else begin
                    exp_pkt = exp_q.pop_front();
                    exp_name = exp_name_q.pop_front();
                    acc = acc_q.pop_front();
                    check_spikes(exp_name, exp_pkt.spikes, out.spikes);
                    check_tick(exp_name, exp_pkt.tick, out.tick);
                    // before any stall, fixed latency and one output per cycle
                    if (!stall_seen && cycle - acc != 4) begin
                        err_proto++;
                        $display("output of %s took %0d cycles instead of 4",
                                 exp_name, cycle - acc);
                    end
                    if (!stall_seen && prev_out >= 0 && cycle - prev_out != 1) begin
                        err_proto++;
                        $display("gap of %0d cycles between outputs in an unstalled stream",
                                 cycle - prev_out);
                    end
                end
                prev_out = cycle;
                rcv_cnt++;
                inflight--;
            end
            if (!out_ready) begin
                stall_seen = 1'b1;
            end
        end
    end

    // limit scales with the table length
    always @(posedge clk) begin
        if (cycle >= timeout_limit) begin
            $display("timeout after %0d cycles, output stopped arriving at %0d of %0d packets",
                     cycle, rcv_cnt, rows.size());
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        arstn = 1'b0;
        src_valid = 1'b0;
        src = '0;
        out_ready = 1'b1;
        cur_rnd = 1'b0;
        cur_stall = 8'hff;
        prev_out = -1;
        build_table();
        timeout_limit = 20 * rows.size() + 100;
        reset_model();
        repeat (3) @(posedge clk);
        arstn <= 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0 || src_ready !== 1'b1) begin
            err_proto++;
            $display("out_valid is not low or src_ready is not high after reset");
        end
        drive_rows();
        while (rcv_cnt < rows.size()) begin
            @(posedge clk);
        end
        // a few more edges to catch any extra output
        repeat (3) @(posedge clk);
        if (!full_seen) begin
            err_proto++;
            $display("src_ready never fell while the output was stalled");
        end
        if (exp_q.size() != 0) begin
            err_proto++;
            $display("%0d expected packets never came out", exp_q.size());
        end
        $display("errors: spikes %0d, tick %0d, protocol %0d", err_spikes, err_tick, err_proto);
        if (err_spikes + err_tick + err_proto == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/network_config_pkg.sv
hw/io_config_pkg.sv
hw/network_source.sv
hw/synapse_stage.sv
hw/neuron_stage.sv
hw/network_sink.sv
hw/network_top.sv
+incdir+dv
dv/network_tb.sv
